/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for failures
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_exec_unit -f vlog.f \
    -o tb_exec_unit > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_exec_unit > sim.log 2>&1
cat sim.log
test -s sim.log || { echo "simulation produced no log"; exit 1; }
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* sim/tb_exec_unit.sv */
/*
  Directed testbench for the Wishbone execute unit. Bus tasks write the
  operands and the instruction, read RESULT and STATUS, and compare them
  with a reference model built from the ISA rules.
*/
`timescale 1ns/1ps

module tb_exec_unit import exec_pkg::*; ();

    localparam int unsigned ACK_TIMEOUT     = 500;    // cycles per bus access
    localparam int unsigned WATCHDOG_CYCLES = 50000;
    localparam longint      S32_MAX         = 64'sd2147483647;
    localparam longint      S32_MIN         = -64'sd2147483648;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    reg_addr_t   adr;
    word_t       dat_w;
    word_t       dat_r;
    logic        ack;
    int unsigned last_wait;                           // negedges until ack, last access
    int unsigned res_wait;                            // same, for the last RESULT read
    int unsigned n_checks = 0;
    word_t       last_result;
    word_t       last_status;

    exec_unit DUT (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    always #20 clk = ~clk;                            // 40 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp)
            abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    // one classic cycle, stb held until ack then dropped
    task automatic bus_cycle(input logic wr, input reg_addr_t a, input word_t d,
                             output word_t rd);
        int unsigned n;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = d;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > ACK_TIMEOUT)
                abort_run($sformatf("no ack within %0d cycles at address %0d", n - 1, a));
        end while (!ack);
        rd = dat_r;                                   // valid while ack is high
        last_wait = n;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_t a, input word_t d);
        word_t unused;
        bus_cycle(1'b1, a, d, unused);
    endtask

    task automatic wb_read(input reg_addr_t a, output word_t d);
        bus_cycle(1'b0, a, '0, d);
    endtask

    // R-type word, rd/rs/rt and the low bits filled with noise
    function automatic word_t rtype(input alu_op_t code, input shamt_t sh);
        word_t junk;
        junk = $urandom;
        return {OPC_RTYPE, junk[26:12], sh, code, junk[1:0]};
    endfunction

    function automatic word_t addi_instr(input logic [16:0] imm);
        word_t junk;
        junk = $urandom;
        return {OPC_ADDI, junk[26:17], imm};
    endfunction

    // expected RESULT and STATUS straight from the ISA rules
    function automatic void model(input word_t a, input word_t b, input word_t instr,
                                  output word_t res, output word_t st);
        logic       addi;
        alu_op_t    code;
        shamt_t     sh;
        word_t      b_eff;
        longint     wide;
        logic       exc;
        exc_id_t    id;
        addi  = (instr[31:27] == OPC_ADDI);
        code  = instr[6:2];
        sh    = instr[11:7];
        b_eff = addi ? {{15{instr[16]}}, instr[16:0]} : b;
        exc   = 1'b0;
        id    = '0;
        res   = '0;
        if (addi || code == ALU_ADD) begin
            wide = longint'($signed(a)) + longint'($signed(b_eff));
            res  = wide[31:0];
            exc  = (wide > S32_MAX) || (wide < S32_MIN);
            id   = addi ? EXC_ADDI : EXC_ADD;
        end else begin
            case (code)
                ALU_SUB: begin
                    wide = longint'($signed(a)) - longint'($signed(b_eff));
                    res  = wide[31:0];
                    exc  = (wide > S32_MAX) || (wide < S32_MIN);
                    id   = EXC_SUB;
                end
                ALU_AND: res = a & b_eff;
                ALU_OR:  res = a | b_eff;
                ALU_SLL: res = a << sh;
                ALU_SRA: res = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                ALU_MUL: begin
                    wide = longint'($signed(a)) * longint'($signed(b_eff));
                    res  = wide[31:0];
                    exc  = (wide > S32_MAX) || (wide < S32_MIN);
                    id   = EXC_MUL;
                end
                ALU_DIV: begin
                    id  = EXC_DIV;
                    exc = (b_eff == '0);
                    if (!exc) begin
                        wide = longint'($signed(a)) / longint'($signed(b_eff));
                        res  = wide[31:0];            // min / -1 keeps the low word
                    end
                end
                default: res = '0;
            endcase
        end
        if (exc)
            res = {29'd0, id};                        // ID replaces the result
        st = '0;
        st[ST_EXC] = exc;
        st[ST_NEQ] = (a != b_eff);
        st[ST_LT]  = (longint'($signed(a)) < longint'($signed(b_eff)));
        st[ST_EXC_ID_LSB +: 3] = exc ? id : 3'd0;
    endfunction

    task automatic exec_and_check(input word_t a, input word_t b, input word_t instr);
        word_t exp_res;
        word_t exp_st;
        model(a, b, instr, exp_res, exp_st);
        wb_write(ADR_OP_A, a);
        wb_write(ADR_OP_B, b);
        wb_write(ADR_INSTR, instr);
        wb_read(ADR_RESULT, last_result);             // stalls until the op is done
        res_wait = last_wait;
        check_eq("result", last_result, exp_res);
        wb_read(ADR_STATUS, last_status);
        check_eq("status", last_status, exp_st);
    endtask

    task automatic reset_state_reads();
        word_t d;
        word_t v;
        wb_read(ADR_RESULT, d);
        check_eq("ack_cycles", word_t'(last_wait), 32'd1);    // idle, no stall
        check_eq("result", d, '0);
        wb_read(ADR_STATUS, d);
        check_eq("ack_cycles", word_t'(last_wait), 32'd1);
        check_eq("status", d, '0);
        v = $urandom;
        wb_write(ADR_OP_A, v);
        wb_read(ADR_OP_A, d);
        check_eq("op_a", d, v);
        v = $urandom;
        wb_write(ADR_OP_B, v);
        wb_read(ADR_OP_B, d);
        check_eq("op_b", d, v);
        wb_read(3'd7, d);                             // unused address
        check_eq("dat_r", d, '0);
        wb_write(ADR_RESULT, 32'hffff_ffff);          // read-only, write dropped
        wb_read(ADR_RESULT, d);
        check_eq("result", d, '0);
    endtask

    task automatic alu_op_sweep();
        alu_op_t codes [0:5] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRA};
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 6; k++)
                exec_and_check($urandom, $urandom, rtype(codes[i], shamt_t'($urandom)));
        end
        exec_and_check(32'h7fff_ffff, 32'h1, rtype(ALU_ADD, 5'd0));
        check_eq("result", last_result, 32'd1);
        exec_and_check(32'h8000_0000, 32'hffff_ffff, rtype(ALU_ADD, 5'd0));
        check_eq("result", last_result, 32'd1);
        exec_and_check(32'h8000_0000, 32'h1, rtype(ALU_SUB, 5'd0));
        check_eq("result", last_result, 32'd3);
        exec_and_check(32'h7fff_ffff, 32'hffff_ffff, rtype(ALU_SUB, 5'd0));
        check_eq("result", last_result, 32'd3);
    endtask

    task automatic addi_immediates();
        word_t r_first;
        exec_and_check(32'd1000, $urandom, addi_instr(17'h00123));
        exec_and_check(32'd1000, $urandom, addi_instr(17'h1ff00));   // -256
        for (int k = 0; k < 4; k++)
            exec_and_check($urandom, $urandom, addi_instr(17'($urandom)));
        exec_and_check(32'h7fff_fff0, 32'h0, addi_instr(17'h00020));
        check_eq("result", last_result, 32'd2);
        exec_and_check(32'h8000_0000, 32'h0, addi_instr(17'h1ffff));
        check_eq("result", last_result, 32'd2);
        // same A and immediate, very different B
        exec_and_check(32'd77, 32'h0, addi_instr(17'h00100));
        r_first = last_result;
        exec_and_check(32'd77, 32'hdead_beef, addi_instr(17'h00100));
        check_eq("result", last_result, r_first);
    endtask

    task automatic mul_div_cases();
        for (int k = 0; k < 4; k++) begin
            exec_and_check(word_t'($signed($urandom) >>> 17),
                           word_t'($signed($urandom) >>> 17), rtype(ALU_MUL, 5'd0));
            check_eq("result_stalled", word_t'(res_wait > 1), 32'd1);
            exec_and_check($urandom, $urandom, rtype(ALU_MUL, 5'd0));
            exec_and_check($urandom, word_t'($signed($urandom) >>> 20), rtype(ALU_DIV, 5'd0));
            check_eq("result_stalled", word_t'(res_wait > 1), 32'd1);
            exec_and_check($urandom, $urandom, rtype(ALU_DIV, 5'd0));
        end
        exec_and_check(32'hffff_fffd, 32'd5, rtype(ALU_MUL, 5'd0));  // -3 * 5
        check_eq("result", last_result, 32'hffff_fff1);
        exec_and_check(32'h0001_0000, 32'h0001_0000, rtype(ALU_MUL, 5'd0));
        check_eq("result", last_result, 32'd4);
        exec_and_check(32'd12345, 32'd0, rtype(ALU_DIV, 5'd0));
        check_eq("result", last_result, 32'd5);
        exec_and_check(32'h8000_0000, 32'hffff_ffff, rtype(ALU_DIV, 5'd0));
        check_eq("result", last_result, 32'h8000_0000);
        exec_and_check(32'hffff_fff9, 32'd2, rtype(ALU_DIV, 5'd0));  // -7 / 2
        check_eq("result", last_result, 32'hffff_fffd);
    endtask

    task automatic flag_compares();
        exec_and_check(32'd5, 32'd5, rtype(ALU_AND, 5'd0));
        exec_and_check(32'hffff_ffff, 32'd1, rtype(ALU_AND, 5'd0));  // signed, not unsigned
        check_eq("status", last_status, 32'd6);
        exec_and_check(32'd1, 32'hffff_ffff, rtype(ALU_AND, 5'd0));
        exec_and_check(32'd3, 32'd9, rtype(ALU_OR, 5'd0));
        exec_and_check(32'h8000_0000, 32'h7fff_ffff, rtype(ALU_OR, 5'd0));
        exec_and_check(32'd10, 32'd99, addi_instr(17'd10));           // equal to the imm
        exec_and_check(32'd10, 32'd0, addi_instr(17'h1fff0));
    endtask

    task automatic held_launch();
        word_t d;
        word_t div_instr;
        word_t sub_instr;
        word_t exp_res;
        word_t exp_st;
        div_instr = rtype(ALU_DIV, 5'd0);
        model(32'd1000, 32'hffff_fff9, div_instr, exp_res, exp_st);
        wb_write(ADR_OP_A, 32'd1000);
        wb_write(ADR_OP_B, 32'hffff_fff9);
        wb_write(ADR_INSTR, div_instr);
        wb_write(ADR_OP_A, 32'd5);                    // lands mid-divide
        check_eq("ack_cycles", word_t'(last_wait), 32'd1);
        wb_read(ADR_RESULT, d);
        check_eq("result", d, exp_res);
        wb_read(ADR_STATUS, d);
        check_eq("status", d, exp_st);
        // second INSTR write has to wait for the divide
        sub_instr = rtype(ALU_SUB, shamt_t'($urandom));
        model(32'd5, 32'hffff_fff9, sub_instr, exp_res, exp_st);
        wb_write(ADR_INSTR, div_instr);
        wb_write(ADR_INSTR, sub_instr);
        check_eq("instr_stalled", word_t'(last_wait > 1), 32'd1);
        wb_read(ADR_RESULT, d);
        check_eq("result", d, exp_res);
        wb_read(ADR_STATUS, d);
        check_eq("status", d, exp_st);
    endtask

    initial begin
        void'($urandom(32'h2213802b));
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        reset_state_reads();
        alu_op_sweep();
        addi_immediates();
        mul_div_cases();
        flag_compares();
        held_launch();
        if (n_checks == 0) begin
            abort_run("no checks were run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    // overall limit in case a task loops forever
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("simulation ran past its cycle limit");
    end

endmodule

/* verilog/alu.sv */
/*
  Single-cycle ALU on the issued operands. Add, sub, and, or, sll and sra,
  plus the not-equal and signed less-than flags. Mul and div codes give 0
  here, their result comes from the iterative unit.
*/
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    exec_if.exec  op,
    output word_t alu_result,
    output logic  neq,
    output logic  lt
);

    word_t sum;
    word_t diff;
    word_t sll_res;
    word_t sra_res;

    assign sum     = op.op_a + op.op_b_eff;
    assign diff    = op.op_a - op.op_b_eff;
    assign sll_res = op.op_a << op.shamt;             // shift amount from the instruction
    assign sra_res = word_t'($signed(op.op_a) >>> op.shamt);

    always_comb begin
        if (op.is_addi) begin
            alu_result = sum;                         // addi ignores the ALU code
        end else begin
            case (op.alu_op)
                ALU_ADD: alu_result = sum;
                ALU_SUB: alu_result = diff;
                ALU_AND: alu_result = op.op_a & op.op_b_eff;
                ALU_OR:  alu_result = op.op_a | op.op_b_eff;
                ALU_SLL: alu_result = sll_res;
                ALU_SRA: alu_result = sra_res;
                default: alu_result = '0;             // mul, div and unused codes
            endcase
        end
    end

    // flags compare A against the effective B
    assign neq = (op.op_a != op.op_b_eff);
    assign lt  = ($signed(op.op_a) < $signed(op.op_b_eff));

endmodule

/* verilog/exec_if.sv */
/*
  Issued operation, as launched by the bus slave. The ALU and the
  multiply/divide unit see it through exec, the result stage through merge.
  All fields hold their value until the next launch; start is a 1-cycle pulse.
*/
`timescale 1ns/1ps

interface exec_if import exec_pkg::*; ();

    word_t   op_a;                                    // operand A as latched at launch
    word_t   op_b_eff;                                // operand B or sign-extended imm
    alu_op_t alu_op;
    shamt_t  shamt;
    logic    is_addi;
    logic    is_muldiv;                               // goes to the iterative unit
    logic    start;

    // bus side drives everything
    modport issue (
        output op_a, op_b_eff, alu_op, shamt, is_addi, is_muldiv, start
    );

    // ALU and multiply/divide unit
    modport exec (
        input op_a, op_b_eff, alu_op, shamt, is_addi, is_muldiv, start
    );

    // result stage needs operands for the overflow check
    modport merge (
        input op_a, op_b_eff, alu_op, is_addi, is_muldiv, start
    );

endinterface

/* verilog/exec_pkg.sv */
/*
  Shared definitions for the execute unit: instruction field positions,
  opcodes, ALU codes, exception IDs, bus word addresses and status bits.
  Every design file pulls in what it needs with a wildcard import.
*/
package exec_pkg;

    localparam int unsigned WORD_W = 32;              // datapath width fixed by the ISA

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [4:0]        opcode_t;              // major opcode
    typedef logic [4:0]        alu_op_t;              // ALU function code
    typedef logic [4:0]        shamt_t;               // shift amount
    typedef logic [2:0]        exc_id_t;              // exception ID written as result
    typedef logic [2:0]        reg_addr_t;            // bus word address

    // instruction field positions
    localparam int unsigned OPC_MSB   = 31;
    localparam int unsigned OPC_LSB   = 27;
    localparam int unsigned ALU_MSB   = 6;
    localparam int unsigned ALU_LSB   = 2;
    localparam int unsigned SHAMT_MSB = 11;
    localparam int unsigned SHAMT_LSB = 7;
    localparam int unsigned IMM_MSB   = 16;           // immediate is bits 16..0

    localparam opcode_t OPC_RTYPE = 5'd0;
    localparam opcode_t OPC_ADDI  = 5'd5;             // anything else runs as R-type

    localparam alu_op_t ALU_ADD = 5'd0;
    localparam alu_op_t ALU_SUB = 5'd1;
    localparam alu_op_t ALU_AND = 5'd2;
    localparam alu_op_t ALU_OR  = 5'd3;
    localparam alu_op_t ALU_SLL = 5'd4;
    localparam alu_op_t ALU_SRA = 5'd5;
    localparam alu_op_t ALU_MUL = 5'd6;
    localparam alu_op_t ALU_DIV = 5'd7;

    localparam exc_id_t EXC_ADD  = 3'd1;
    localparam exc_id_t EXC_ADDI = 3'd2;
    localparam exc_id_t EXC_SUB  = 3'd3;
    localparam exc_id_t EXC_MUL  = 3'd4;
    localparam exc_id_t EXC_DIV  = 3'd5;

    localparam reg_addr_t ADR_OP_A   = 3'd0;
    localparam reg_addr_t ADR_OP_B   = 3'd1;
    localparam reg_addr_t ADR_INSTR  = 3'd2;          // write launches the operation
    localparam reg_addr_t ADR_RESULT = 3'd3;
    localparam reg_addr_t ADR_STATUS = 3'd4;

    // status word layout
    localparam int unsigned ST_EXC        = 0;
    localparam int unsigned ST_NEQ        = 1;
    localparam int unsigned ST_LT         = 2;
    localparam int unsigned ST_EXC_ID_LSB = 3;        // 3-bit ID in bits 5..3

    localparam int unsigned MULDIV_STEPS = 32;        // iterations per mul or div

endpackage

/* verilog/exec_unit.sv */
/*
  Stand-alone execute unit on a Wishbone classic slave bus.
  Write OP_A, OP_B, then INSTR to launch; read RESULT and STATUS back.
  Only wiring here, the work is done in the sub-blocks.
*/
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  reg_addr_t adr,
    input  word_t     dat_w,
    output word_t     dat_r,
    output logic      ack
);

    word_t alu_result;
    word_t md_result;
    word_t result;
    word_t status;
    logic  neq;
    logic  lt;
    logic  md_done;
    logic  md_exc;
    logic  result_valid;                              // low while an operation runs

    exec_if op_if ();                                 // issued operation

    wb_exec_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .dat_r(dat_r), .ack(ack),
        .op(op_if),
        .result_valid(result_valid), .result(result), .status(status)
    );

    alu u_alu (.op(op_if), .alu_result(alu_result), .neq(neq), .lt(lt));

    multdiv u_multdiv (
        .clk(clk), .rst_n(rst_n), .op(op_if),
        .md_result(md_result), .md_done(md_done), .md_exc(md_exc)
    );

    result_merge u_merge (
        .clk(clk), .rst_n(rst_n), .op(op_if),
        .alu_result(alu_result), .neq(neq), .lt(lt),
        .md_result(md_result), .md_done(md_done), .md_exc(md_exc),
        .result_valid(result_valid), .result(result), .status(status)
    );

endmodule

/* verilog/multdiv.sv */
/*
  Iterative signed multiply/divide. Works on magnitudes for MULDIV_STEPS
  cycles after a start with is_muldiv set, then pulses md_done for one
  cycle with md_result and md_exc valid. Multiply is shift-add, divide is
  restoring with the quotient truncated toward zero.
*/
`timescale 1ns/1ps

module multdiv import exec_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    exec_if.exec  op,
    output word_t md_result,
    output logic  md_done,
    output logic  md_exc
);

    localparam int unsigned CNT_W = $clog2(MULDIV_STEPS);

    logic                busy;
    logic                fin;                         // one cycle after the last step
    logic                is_div;
    logic                res_neg;                     // operand signs differ
    logic                div_zero;
    logic [CNT_W-1:0]    cnt;
    word_t               mcand;                       // multiplicand or divisor magnitude
    logic [2*WORD_W-1:0] p;                           // hi: partial sum / remainder
    logic [2*WORD_W-1:0] prod_s;
    logic [WORD_W:0]     add_sum;
    logic [WORD_W:0]     rem_sh;
    logic [WORD_W:0]     trial;
    word_t               quo_s;
    logic                go;

    function automatic word_t mag(input word_t v);
        return v[WORD_W-1] ? -v : v;                  // most negative stays 2**31 unsigned
    endfunction

    assign go = op.start & op.is_muldiv;

    // one multiply step: add if low bit set, then shift right
    assign add_sum = {1'b0, p[2*WORD_W-1:WORD_W]} + (p[0] ? {1'b0, mcand} : '0);
    // one divide step: shift next dividend bit into the remainder and try
    assign rem_sh  = {p[2*WORD_W-1:WORD_W], p[WORD_W-1]};
    assign trial   = rem_sh - {1'b0, mcand};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            fin  <= 1'b0;
            cnt  <= '0;
        end else begin
            fin <= 1'b0;
            if (go) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(MULDIV_STEPS - 1)) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            is_div   <= (op.alu_op == ALU_DIV);
            res_neg  <= op.op_a[WORD_W-1] ^ op.op_b_eff[WORD_W-1];
            div_zero <= (op.op_b_eff == '0);          // still iterated, result dropped
            mcand    <= mag(op.op_b_eff);
            p        <= {{WORD_W{1'b0}}, mag(op.op_a)};
        end else if (busy) begin
            if (is_div) begin
                if (trial[WORD_W])
                    p <= {rem_sh[WORD_W-1:0], p[WORD_W-2:0], 1'b0};   // restore
                else
                    p <= {trial[WORD_W-1:0], p[WORD_W-2:0], 1'b1};
            end else begin
                p <= {add_sum, p[WORD_W-1:1]};
            end
        end
    end

    // sign fix-up at the end
    assign prod_s = res_neg ? -p : p;
    assign quo_s  = res_neg ? -p[WORD_W-1:0] : p[WORD_W-1:0];    // min / -1 wraps to min

    assign md_result = is_div ? quo_s : prod_s[WORD_W-1:0];
    assign md_exc    = is_div ? div_zero
                              : (prod_s[2*WORD_W-1:WORD_W] != {WORD_W{prod_s[WORD_W-1]}});
    assign md_done   = fin;

endmodule

/* verilog/result_merge.sv */
/*
  Result stage. Takes the ALU result on start, or the multiply/divide
  result on md_done, and swaps in the exception ID when the operation
  faults. Holds the RESULT and STATUS words and the result_valid flag.
*/
`timescale 1ns/1ps

module result_merge import exec_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    exec_if.merge op,
    input  word_t alu_result,
    input  logic  neq,
    input  logic  lt,
    input  word_t md_result,
    input  logic  md_done,
    input  logic  md_exc,
    output logic  result_valid,
    output word_t result,
    output word_t status
);

    logic    is_add;
    logic    is_sub;
    logic    add_ovf;
    logic    sub_ovf;
    logic    alu_exc;
    exc_id_t alu_id;
    exc_id_t md_id;

    function automatic word_t pack_status(input logic exc, input exc_id_t id,
                                          input logic ne, input logic lo);
        word_t s;
        s = '0;
        s[ST_EXC] = exc;
        s[ST_NEQ] = ne;
        s[ST_LT]  = lo;
        s[ST_EXC_ID_LSB +: $bits(exc_id_t)] = exc ? id : '0;
        return s;
    endfunction

    assign is_add  = op.is_addi | (op.alu_op == ALU_ADD);
    assign is_sub  = ~op.is_addi & (op.alu_op == ALU_SUB);
    // signed overflow from operand and result signs
    assign add_ovf = (op.op_a[WORD_W-1] == op.op_b_eff[WORD_W-1]) &
                     (alu_result[WORD_W-1] != op.op_a[WORD_W-1]);
    assign sub_ovf = (op.op_a[WORD_W-1] != op.op_b_eff[WORD_W-1]) &
                     (alu_result[WORD_W-1] != op.op_a[WORD_W-1]);
    assign alu_exc = (is_add & add_ovf) | (is_sub & sub_ovf);
    assign alu_id  = op.is_addi ? EXC_ADDI : (is_sub ? EXC_SUB : EXC_ADD);
    assign md_id   = (op.alu_op == ALU_DIV) ? EXC_DIV : EXC_MUL;   // alu_op held since launch

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b1;                     // idle counts as done
            result       <= '0;
            status       <= '0;
        end else if (op.start) begin
            if (op.is_muldiv) begin
                result_valid <= 1'b0;                 // wait for md_done
                status       <= pack_status(1'b0, alu_id, neq, lt);
            end else begin
                result_valid <= 1'b1;
                result       <= alu_exc ? word_t'(alu_id) : alu_result;
                status       <= pack_status(alu_exc, alu_id, neq, lt);
            end
        end else if (md_done) begin
            result_valid <= 1'b1;
            result       <= md_exc ? word_t'(md_id) : md_result;
            status       <= pack_status(md_exc, md_id, status[ST_NEQ], status[ST_LT]);
        end
    end

endmodule

/* verilog/wb_exec_regs.sv */
/*
  Wishbone classic slave holding the operand and instruction registers.
  A write to INSTR decodes the word and launches it on the exec interface.
  Result and status reads, and INSTR writes, stall while an operation runs.
*/
`timescale 1ns/1ps

module wb_exec_regs import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  reg_addr_t adr,
    input  word_t     dat_w,
    output word_t     dat_r,
    output logic      ack,
    exec_if.issue     op,
    input  logic      result_valid,
    input  word_t     result,
    input  word_t     status
);

    word_t   reg_a;                                   // OP_A as seen by the bus
    word_t   reg_b;
    word_t   reg_instr;
    word_t   imm_ext;
    opcode_t opcode;
    alu_op_t alu_code;
    logic    access;
    logic    rd_result;
    logic    wr_instr;
    logic    hold;
    logic    take;
    logic    launch;

    assign access    = cyc & stb & ~ack;              // new request, not the acked one
    assign rd_result = ~we & ((adr == ADR_RESULT) | (adr == ADR_STATUS));
    assign wr_instr  = we & (adr == ADR_INSTR);
    assign hold      = ~result_valid & (rd_result | wr_instr);    // back-pressure
    assign take      = access & ~hold;
    assign launch    = take & wr_instr;

    // decode straight from the bus word so issue fields line up with start
    assign opcode   = dat_w[OPC_MSB:OPC_LSB];
    assign alu_code = dat_w[ALU_MSB:ALU_LSB];
    assign imm_ext  = {{(WORD_W-IMM_MSB-1){dat_w[IMM_MSB]}}, dat_w[IMM_MSB:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack      <= 1'b0;
            op.start <= 1'b0;
        end else begin
            ack      <= take;                         // one cycle wide
            op.start <= launch;                       // same cycle as the INSTR ack
        end
    end

    // register writes, read-only addresses fall through
    always_ff @(posedge clk) begin
        if (take && we) begin
            case (adr)
                ADR_OP_A:  reg_a     <= dat_w;
                ADR_OP_B:  reg_b     <= dat_w;
                ADR_INSTR: reg_instr <= dat_w;
                default:   ;
            endcase
        end
    end

    // read data valid with ack
    always_ff @(posedge clk) begin
        if (take && !we) begin
            case (adr)
                ADR_OP_A:   dat_r <= reg_a;
                ADR_OP_B:   dat_r <= reg_b;
                ADR_INSTR:  dat_r <= reg_instr;
                ADR_RESULT: dat_r <= result;
                ADR_STATUS: dat_r <= status;
                default:    dat_r <= '0;              // unused addresses
            endcase
        end
    end

    // latch the issued operation, later OP_A/OP_B writes leave it alone
    always_ff @(posedge clk) begin
        if (launch) begin
            op.op_a      <= reg_a;
            op.op_b_eff  <= (opcode == OPC_ADDI) ? imm_ext : reg_b;
            op.alu_op    <= alu_code;
            op.shamt     <= dat_w[SHAMT_MSB:SHAMT_LSB];
            op.is_addi   <= (opcode == OPC_ADDI);
            op.is_muldiv <= (opcode != OPC_ADDI) &
                            ((alu_code == ALU_MUL) | (alu_code == ALU_DIV));
        end
    end

endmodule

/* vlog.f */
verilog/exec_pkg.sv
verilog/exec_if.sv
verilog/wb_exec_regs.sv
verilog/alu.sv
verilog/multdiv.sv
verilog/result_merge.sv
verilog/exec_unit.sv
sim/tb_exec_unit.sv
